// ==== hw/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // Bus and word geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int STRB_W         = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFS_W         = 4;     // Byte offset within a line

    // AXI read IDs, one per requester
    localparam int                  AXI_ID_W = 4;
    localparam logic [AXI_ID_W-1:0] INST_ID  = 4'd0;
    localparam logic [AXI_ID_W-1:0] DATA_ID  = 4'd1;

    // AXI size codes
    localparam logic [2:0] SIZE_WORD = 3'd2;  // 4 bytes
    localparam logic [2:0] SIZE_LINE = 3'd4;  // 16 bytes

    // One bus line, seen whole or as word lanes
    typedef union packed {
        logic [LINE_W-1:0]                     line;
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
    } line_u;

    // Byte enables of a single word
    typedef logic [3:0] word_strb_t;

endpackage

// ==== hw/mem_req_if.sv ====
interface mem_req_if;
    import mem_bus_pkg::*;

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;    // AXI size code
    line_u             wdata;
    logic [STRB_W-1:0] wstrb;
    logic              rdy;     // Acceptance pulse
    logic              rvalid;  // Completion pulse, read data or write response
    line_u             rdata;

    modport requester (
        output req, we, addr, size, wdata, wstrb,
        input  rdy, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, size, wdata, wstrb,
        output rdy, rvalid, rdata
    );

endinterface

// ==== hw/fetch_line_buffer.sv ====
module fetch_line_buffer (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           fetch_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                           fetch_valid_o,
    output logic [mem_bus_pkg::WORD_W-1:0] fetch_instr_o,
    mem_req_if.requester                   bus
);
    import mem_bus_pkg::*;

    line_u                    line_q;
    logic [ADDR_W-OFFS_W-1:0] tag_q;
    logic                     line_vld_q;
    logic                     busy_q;       // Refill in progress
    logic                     req_q;
    logic [ADDR_W-1:0]        miss_addr_q;
    logic                     accept;
    logic                     hit;

    assign accept = fetch_strobe_i && !busy_q;
    assign hit    = line_vld_q && (tag_q == fetch_addr_i[ADDR_W-1:OFFS_W]);

    // Refill always asks for the whole aligned line
    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.addr  = {miss_addr_q[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign bus.size  = SIZE_LINE;
    assign bus.wdata = '0;
    assign bus.wstrb = '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            line_vld_q    <= 1'b0;
            busy_q        <= 1'b0;
            req_q         <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            if (accept && hit) begin
                fetch_valid_o <= 1'b1;
            end else if (accept) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
            end
            if (req_q && bus.rdy)
                req_q <= 1'b0;
            if (busy_q && bus.rvalid) begin
                busy_q        <= 1'b0;
                line_vld_q    <= 1'b1;
                fetch_valid_o <= 1'b1;  // Answer the missed fetch
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !hit)
            miss_addr_q <= fetch_addr_i;
        if (busy_q && bus.rvalid) begin
            line_q        <= bus.rdata;
            tag_q         <= miss_addr_q[ADDR_W-1:OFFS_W];
            fetch_instr_o <= bus.rdata.words[miss_addr_q[OFFS_W-1:2]];
        end else if (accept && hit) begin
            fetch_instr_o <= line_q.words[fetch_addr_i[OFFS_W-1:2]];
        end
    end

    a_no_fetch_during_refill: assert property (
        @(posedge clk) disable iff (!arst_n_i) fetch_strobe_i |-> !busy_q
    ) else $error("fetch strobe while a line refill is pending");

endmodule

// ==== hw/data_access_unit.sv ====
module data_access_unit (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           load_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] load_addr_i,
    input  logic                           store_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0] store_addr_i,
    input  logic [mem_bus_pkg::WORD_W-1:0] store_data_i,
    input  mem_bus_pkg::word_strb_t        store_strb_i,
    output logic                           load_valid_o,
    output logic [mem_bus_pkg::WORD_W-1:0] load_data_o,
    output logic                           store_done_o,
    mem_req_if.requester                   bus
);
    import mem_bus_pkg::*;

    logic              busy_q;
    logic              req_q;
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;     // Word aligned
    line_u             wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic              do_load;
    logic              do_store;
    line_u             st_line;
    logic [STRB_W-1:0] st_strb;

    assign do_load  = load_strobe_i && !busy_q;
    assign do_store = store_strobe_i && !busy_q && !load_strobe_i;

    // Store word goes into its own lane, strobe shifted to match
    always_comb begin
        st_line.line                         = '0;
        st_line.words[store_addr_i[OFFS_W-1:2]] = store_data_i;
    end
    assign st_strb = STRB_W'(store_strb_i) << {store_addr_i[OFFS_W-1:2], 2'b00};

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.size  = SIZE_WORD;
    assign bus.wdata = wdata_q;
    assign bus.wstrb = wstrb_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q       <= 1'b0;
            req_q        <= 1'b0;
            we_q         <= 1'b0;
            load_valid_o <= 1'b0;
            store_done_o <= 1'b0;
        end else begin
            load_valid_o <= 1'b0;
            store_done_o <= 1'b0;
            if (do_load || do_store) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
                we_q   <= do_store;
            end
            if (req_q && bus.rdy)
                req_q <= 1'b0;
            if (busy_q && bus.rvalid) begin
                busy_q       <= 1'b0;
                load_valid_o <= !we_q;
                store_done_o <= we_q;   // Write response seen
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_load) begin
            addr_q  <= {load_addr_i[ADDR_W-1:2], 2'b00};
            wstrb_q <= '0;
        end else if (do_store) begin
            addr_q  <= {store_addr_i[ADDR_W-1:2], 2'b00};
            wdata_q <= st_line;
            wstrb_q <= st_strb;
        end
        if (busy_q && bus.rvalid && !we_q)
            load_data_o <= bus.rdata.words[addr_q[OFFS_W-1:2]];
    end

    a_no_dual_strobe: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(load_strobe_i && store_strobe_i)
    ) else $error("load and store strobed in the same cycle");

    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n_i) (load_strobe_i || store_strobe_i) |-> !busy_q
    ) else $error("data access strobed while the unit is busy");

endmodule

// ==== hw/bus_arbiter.sv ====
module bus_arbiter (
    input  logic                             clk,
    input  logic                             arst_n_i,
    mem_req_if.arbiter                       inst_bus,
    mem_req_if.arbiter                       data_bus,
    // AXI read address
    output logic [mem_bus_pkg::AXI_ID_W-1:0] arid_o,
    output logic [mem_bus_pkg::ADDR_W-1:0]   araddr_o,
    output logic [2:0]                       arsize_o,
    output logic                             arvalid_o,
    input  logic                             arready_i,
    // AXI read data
    input  logic [mem_bus_pkg::AXI_ID_W-1:0] rid_i,
    input  logic [mem_bus_pkg::LINE_W-1:0]   rdata_i,
    input  logic                             rvalid_i,
    output logic                             rready_o,
    // AXI write address and data
    output logic [mem_bus_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [2:0]                       awsize_o,
    output logic                             awvalid_o,
    input  logic                             awready_i,
    output logic [mem_bus_pkg::LINE_W-1:0]   wdata_o,
    output logic [mem_bus_pkg::STRB_W-1:0]   wstrb_o,
    output logic                             wvalid_o,
    input  logic                             wready_i,
    // AXI write response
    input  logic                             bvalid_i,
    output logic                             bready_o
);
    import mem_bus_pkg::*;

    logic                rd_busy_q;     // One read outstanding at most
    logic                wr_busy_q;
    logic                data_rd_acc;
    logic                inst_rd_acc;
    logic                data_wr_acc;
    logic                rsp_vld_q;
    logic [AXI_ID_W-1:0] rsp_id_q;
    line_u               rsp_data_q;
    logic                wr_done_q;

    // Data read beats instruction read
    assign data_rd_acc = data_bus.req && !data_bus.we && !rd_busy_q;
    assign inst_rd_acc = inst_bus.req && !inst_bus.we && !rd_busy_q && !data_rd_acc;
    assign data_wr_acc = data_bus.req && data_bus.we && !wr_busy_q;

    assign inst_bus.rdy = inst_rd_acc;
    assign data_bus.rdy = data_rd_acc || data_wr_acc;

    // Return path, routed by the ID that came back
    assign inst_bus.rvalid = rsp_vld_q && (rsp_id_q == INST_ID);
    assign data_bus.rvalid = (rsp_vld_q && (rsp_id_q == DATA_ID)) || wr_done_q;
    assign inst_bus.rdata  = rsp_data_q;
    assign data_bus.rdata  = rsp_data_q;

    assign rready_o = rd_busy_q;
    assign bready_o = wr_busy_q && !awvalid_o && !wvalid_o;

    // Read channel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_busy_q <= 1'b0;
            arvalid_o <= 1'b0;
            rsp_vld_q <= 1'b0;
        end else begin
            rsp_vld_q <= 1'b0;
            if (data_rd_acc || inst_rd_acc) begin
                rd_busy_q <= 1'b1;
                arvalid_o <= 1'b1;
            end
            if (arvalid_o && arready_i)
                arvalid_o <= 1'b0;
            if (rvalid_i && rready_o) begin
                rd_busy_q <= 1'b0;
                rsp_vld_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd_acc) begin
            arid_o   <= DATA_ID;
            araddr_o <= data_bus.addr;
            arsize_o <= data_bus.size;
        end else if (inst_rd_acc) begin
            arid_o   <= INST_ID;
            araddr_o <= inst_bus.addr;
            arsize_o <= inst_bus.size;
        end
        if (rvalid_i && rready_o) begin
            rsp_id_q   <= rid_i;
            rsp_data_q <= rdata_i;
        end
    end

    // Write channel, address and data leave together
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_busy_q <= 1'b0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            wr_done_q <= 1'b0;
            if (data_wr_acc) begin
                wr_busy_q <= 1'b1;
                awvalid_o <= 1'b1;
                wvalid_o  <= 1'b1;
            end
            if (awvalid_o && awready_i)
                awvalid_o <= 1'b0;
            if (wvalid_o && wready_i)
                wvalid_o <= 1'b0;
            if (bvalid_i && bready_o) begin
                wr_busy_q <= 1'b0;
                wr_done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr_acc) begin
            awaddr_o <= data_bus.addr;
            awsize_o <= data_bus.size;
            wdata_o  <= data_bus.wdata.line;
            wstrb_o  <= data_bus.wstrb;
        end
    end

    a_rid_matches: assert property (
        @(posedge clk) disable iff (!arst_n_i) (rvalid_i && rready_o) |-> (rid_i == arid_o)
    ) else $error("read data ID does not match the outstanding read");

endmodule

// ==== hw/mem_subsys_top.sv ====
module mem_subsys_top (
    input  logic                             clk,
    input  logic                             arst_n_i,
    // Fetch side
    input  logic                             fetch_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]   fetch_addr_i,
    output logic                             fetch_valid_o,
    output logic [mem_bus_pkg::WORD_W-1:0]   fetch_instr_o,
    // Load side
    input  logic                             load_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]   load_addr_i,
    output logic                             load_valid_o,
    output logic [mem_bus_pkg::WORD_W-1:0]   load_data_o,
    // Store side
    input  logic                             store_strobe_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]   store_addr_i,
    input  logic [mem_bus_pkg::WORD_W-1:0]   store_data_i,
    input  mem_bus_pkg::word_strb_t          store_strb_i,
    output logic                             store_done_o,
    // AXI read address
    output logic [mem_bus_pkg::AXI_ID_W-1:0] arid_o,
    output logic [mem_bus_pkg::ADDR_W-1:0]   araddr_o,
    output logic [2:0]                       arsize_o,
    output logic                             arvalid_o,
    input  logic                             arready_i,
    // AXI read data
    input  logic [mem_bus_pkg::AXI_ID_W-1:0] rid_i,
    input  logic [mem_bus_pkg::LINE_W-1:0]   rdata_i,
    input  logic                             rvalid_i,
    output logic                             rready_o,
    // AXI write address
    output logic [mem_bus_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [2:0]                       awsize_o,
    output logic                             awvalid_o,
    input  logic                             awready_i,
    // AXI write data
    output logic [mem_bus_pkg::LINE_W-1:0]   wdata_o,
    output logic [mem_bus_pkg::STRB_W-1:0]   wstrb_o,
    output logic                             wvalid_o,
    input  logic                             wready_i,
    // AXI write response
    input  logic                             bvalid_i,
    output logic                             bready_o
);

    mem_req_if inst_bus ();  // Fetch buffer, reads only
    mem_req_if data_bus ();

    fetch_line_buffer fetch_line_buffer_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_instr_o  (fetch_instr_o),
        .bus            (inst_bus.requester)
    );

    data_access_unit data_access_unit_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .load_strobe_i  (load_strobe_i),
        .load_addr_i    (load_addr_i),
        .store_strobe_i (store_strobe_i),
        .store_addr_i   (store_addr_i),
        .store_data_i   (store_data_i),
        .store_strb_i   (store_strb_i),
        .load_valid_o   (load_valid_o),
        .load_data_o    (load_data_o),
        .store_done_o   (store_done_o),
        .bus            (data_bus.requester)
    );

    bus_arbiter bus_arbiter_inst (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .inst_bus  (inst_bus.arbiter),
        .data_bus  (data_bus.arbiter),
        .arid_o    (arid_o),
        .araddr_o  (araddr_o),
        .arsize_o  (arsize_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rid_i     (rid_i),
        .rdata_i   (rdata_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .awaddr_o  (awaddr_o),
        .awsize_o  (awsize_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

// ==== tests/axi_mem_model.sv ====
module axi_mem_model #(
    parameter int AR_DELAY = 2,
    parameter int R_DELAY  = 3,
    parameter int B_DELAY  = 2
) (
    input  logic                             clk,
    input  logic [mem_bus_pkg::AXI_ID_W-1:0] arid_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]   araddr_i,
    input  logic [2:0]                       arsize_i,
    input  logic                             arvalid_i,
    output logic                             arready_o,
    output logic [mem_bus_pkg::AXI_ID_W-1:0] rid_o,
    output logic [mem_bus_pkg::LINE_W-1:0]   rdata_o,
    output logic                             rvalid_o,
    input  logic                             rready_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic                             awvalid_i,
    output logic                             awready_o,
    input  logic [mem_bus_pkg::LINE_W-1:0]   wdata_i,
    input  logic [mem_bus_pkg::STRB_W-1:0]   wstrb_i,
    input  logic                             wvalid_i,
    output logic                             wready_o,
    output logic                             bvalid_o,
    input  logic                             bready_i
);
    import mem_bus_pkg::*;

    localparam int MEM_BYTES = 4096;
    localparam int LOG_DEPTH = 32;

    logic [7:0]          mem [MEM_BYTES];
    logic [31:0]         byte_addr;
    logic [31:0]         fill_word;
    int                  ar_count;
    logic [ADDR_W-1:0]   ar_addr_log [LOG_DEPTH];    // One entry per AR handshake
    logic [2:0]          ar_size_log [LOG_DEPTH];
    logic [AXI_ID_W-1:0] ar_id_log   [LOG_DEPTH];

    // Whole aligned line, a single beat carries all 16 byte lanes
    function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int b = 0; b < STRB_W; b++)
            line[8*b +: 8] = mem[{addr[11:4], 4'b0000} + b];
        return line;
    endfunction

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            byte_addr = a;
            fill_word = {byte_addr[31:2], 2'b00} ^ 32'h5a5a_0000;
            mem[a]    = fill_word[8*byte_addr[1:0] +: 8];
        end
    end

    initial begin : read_channel
        logic [ADDR_W-1:0]   addr;
        logic [AXI_ID_W-1:0] id;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rid_o     = '0;
        rdata_o   = '0;
        ar_count  = 0;
        forever begin
            @(posedge clk);
            if (arvalid_i) begin
                repeat (AR_DELAY) @(posedge clk);
                arready_o <= 1'b1;
                @(posedge clk);         // arvalid held, handshake on this edge
                arready_o <= 1'b0;
                addr = araddr_i;
                id   = arid_i;
                if (ar_count < LOG_DEPTH) begin
                    ar_addr_log[ar_count] = araddr_i;
                    ar_size_log[ar_count] = arsize_i;
                    ar_id_log[ar_count]   = arid_i;
                end
                ar_count++;
                repeat (R_DELAY) @(posedge clk);
                rid_o    <= id;
                rdata_o  <= line_at(addr);
                rvalid_o <= 1'b1;
                do @(posedge clk); while (!rready_i);
                rvalid_o <= 1'b0;
            end
        end
    end

    initial begin : write_channel
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        forever begin
            @(posedge clk);
            if (awvalid_i && wvalid_i) begin
                awready_o <= 1'b1;
                wready_o  <= 1'b1;
                @(posedge clk);
                awready_o <= 1'b0;
                wready_o  <= 1'b0;
                for (int b = 0; b < STRB_W; b++) begin
                    if (wstrb_i[b])
                        mem[{awaddr_i[11:4], 4'b0000} + b] = wdata_i[8*b +: 8];
                end
                repeat (B_DELAY) @(posedge clk);
                bvalid_o <= 1'b1;
                do @(posedge clk); while (!bready_i);
                bvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_mem_subsys.sv ====
module tb_mem_subsys;
    import mem_bus_pkg::*;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 10;
    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 200;
    localparam int          WAIT_LIMIT      = 100;
    localparam logic [31:0] SEED            = 32'hdb0a_735e;

    logic                clk = 1'b0;
    logic                arst_n_i;
    logic                fetch_strobe_i;
    logic [ADDR_W-1:0]   fetch_addr_i;
    logic                fetch_valid_o;
    logic [WORD_W-1:0]   fetch_instr_o;
    logic                load_strobe_i;
    logic [ADDR_W-1:0]   load_addr_i;
    logic                load_valid_o;
    logic [WORD_W-1:0]   load_data_o;
    logic                store_strobe_i;
    logic [ADDR_W-1:0]   store_addr_i;
    logic [WORD_W-1:0]   store_data_i;
    word_strb_t          store_strb_i;
    logic                store_done_o;
    logic [AXI_ID_W-1:0] arid;
    logic [ADDR_W-1:0]   araddr;
    logic [2:0]          arsize;
    logic                arvalid;
    logic                arready;
    logic [AXI_ID_W-1:0] rid;
    logic [LINE_W-1:0]   rdata;
    logic                rvalid;
    logic                rready;
    logic [ADDR_W-1:0]   awaddr;
    logic [2:0]          awsize;
    logic                awvalid;
    logic                awready;
    logic [LINE_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
    logic                wvalid;
    logic                wready;
    logic                bvalid;
    logic                bready;

    string cur_test;
    int    err_count;
    int    check_count;
    int    test_count;
    int    failed_tests;
    int    test_errs_start;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_subsys_top mem_subsys_top_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_instr_o  (fetch_instr_o),
        .load_strobe_i  (load_strobe_i),
        .load_addr_i    (load_addr_i),
        .load_valid_o   (load_valid_o),
        .load_data_o    (load_data_o),
        .store_strobe_i (store_strobe_i),
        .store_addr_i   (store_addr_i),
        .store_data_i   (store_data_i),
        .store_strb_i   (store_strb_i),
        .store_done_o   (store_done_o),
        .arid_o         (arid),
        .araddr_o       (araddr),
        .arsize_o       (arsize),
        .arvalid_o      (arvalid),
        .arready_i      (arready),
        .rid_i          (rid),
        .rdata_i        (rdata),
        .rvalid_i       (rvalid),
        .rready_o       (rready),
        .awaddr_o       (awaddr),
        .awsize_o       (awsize),
        .awvalid_o      (awvalid),
        .awready_i      (awready),
        .wdata_o        (wdata),
        .wstrb_o        (wstrb),
        .wvalid_o       (wvalid),
        .wready_i       (wready),
        .bvalid_i       (bvalid),
        .bready_o       (bready)
    );

    axi_mem_model #(
        .AR_DELAY (2),
        .R_DELAY  (3),
        .B_DELAY  (2)
    ) axi_mem_model_inst (
        .clk       (clk),
        .arid_i    (arid),
        .araddr_i  (araddr),
        .arsize_i  (arsize),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rid_o     (rid),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

    // Memory contents before any store
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input word_strb_t  strb);
        logic [31:0] merged;
        for (int b = 0; b < 4; b++)
            merged[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        return merged;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %h actual %h", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        test_errs_start = err_count;
        test_count++;
    endtask

    task automatic end_test();
        if (err_count == test_errs_start) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, err_count - test_errs_start);
            failed_tests++;
        end
    endtask

    // Strobes are set on the current edge and cleared on the next
    task automatic issue_fetch(input logic [31:0] addr);
        fetch_strobe_i <= 1'b1;
        fetch_addr_i   <= addr;
    endtask

    task automatic issue_load(input logic [31:0] addr);
        load_strobe_i <= 1'b1;
        load_addr_i   <= addr;
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                               input word_strb_t strb);
        store_strobe_i <= 1'b1;
        store_addr_i   <= addr;
        store_data_i   <= data;
        store_strb_i   <= strb;
    endtask

    task automatic release_strobes();
        @(posedge clk);
        fetch_strobe_i <= 1'b0;
        load_strobe_i  <= 1'b0;
        store_strobe_i <= 1'b0;
    endtask

    task automatic wait_fetch(output int cycles, output logic [31:0] data);
        logic seen;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            seen = fetch_valid_o;
            data = fetch_instr_o;
        end while (!seen && cycles < WAIT_LIMIT);
        if (!seen) begin
            $display("ERROR %s: no fetch response within %0d cycles", cur_test, WAIT_LIMIT);
            err_count++;
        end
    endtask

    task automatic wait_load(output logic [31:0] data);
        logic seen;
        int   cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            seen = load_valid_o;
            data = load_data_o;
        end while (!seen && cycles < WAIT_LIMIT);
        if (!seen) begin
            $display("ERROR %s: no load response within %0d cycles", cur_test, WAIT_LIMIT);
            err_count++;
        end
    endtask

    task automatic wait_store();
        logic seen;
        int   cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            seen = store_done_o;
        end while (!seen && cycles < WAIT_LIMIT);
        if (!seen) begin
            $display("ERROR %s: store never completed within %0d cycles", cur_test, WAIT_LIMIT);
            err_count++;
        end
    endtask

    task automatic test_fetch_miss();
        int          n;
        int          cycles;
        logic [31:0] data;
        begin_test("fetch_miss");
        n = axi_mem_model_inst.ar_count;
        @(posedge clk);
        issue_fetch(32'h0000_0108);
        release_strobes();
        wait_fetch(cycles, data);
        check("instr", init_word(32'h0000_0108), data);
        check("ar count", n + 1, axi_mem_model_inst.ar_count);
        check("araddr", 32'h0000_0100, axi_mem_model_inst.ar_addr_log[n]);
        check("arsize", SIZE_LINE, axi_mem_model_inst.ar_size_log[n]);
        check("arid", INST_ID, axi_mem_model_inst.ar_id_log[n]);
        end_test();
    endtask

    task automatic test_fetch_hit();
        int          n;
        int          cycles;
        logic [31:0] data;
        begin_test("fetch_hit");
        n = axi_mem_model_inst.ar_count;
        @(posedge clk);
        issue_fetch(32'h0000_010c);    // Same line as the miss
        release_strobes();
        wait_fetch(cycles, data);
        check("instr", init_word(32'h0000_010c), data);
        check("hit latency", 1, cycles);
        check("ar count", n, axi_mem_model_inst.ar_count);
        end_test();
    endtask

    task automatic test_line_replace();
        int          n;
        int          cycles;
        logic [31:0] data;
        begin_test("line_replace");
        n = axi_mem_model_inst.ar_count;
        @(posedge clk);
        issue_fetch(32'h0000_0024);
        release_strobes();
        wait_fetch(cycles, data);
        check("instr", init_word(32'h0000_0024), data);
        check("ar count", n + 1, axi_mem_model_inst.ar_count);
        check("araddr", 32'h0000_0020, axi_mem_model_inst.ar_addr_log[n]);
        end_test();
    endtask

    task automatic test_store_then_load();
        int          n;
        logic [31:0] st_data;
        logic [31:0] data;
        begin_test("store_then_load");
        st_data = $urandom;
        @(posedge clk);
        issue_store(32'h0000_0208, st_data, 4'b0101);
        release_strobes();
        wait_store();
        check("awsize", SIZE_WORD, awsize);
        n = axi_mem_model_inst.ar_count;
        @(posedge clk);
        issue_load(32'h0000_0208);
        release_strobes();
        wait_load(data);
        check("load data", merge_bytes(init_word(32'h0000_0208), st_data, 4'b0101), data);
        check("ar count", n + 1, axi_mem_model_inst.ar_count);
        check("araddr", 32'h0000_0208, axi_mem_model_inst.ar_addr_log[n]);
        check("arsize", SIZE_WORD, axi_mem_model_inst.ar_size_log[n]);
        check("arid", DATA_ID, axi_mem_model_inst.ar_id_log[n]);
        end_test();
    endtask

    task automatic test_fetch_and_load();
        int          n;
        int          cycles;
        logic [31:0] f_data;
        logic [31:0] l_data;
        begin_test("fetch_and_load");
        n = axi_mem_model_inst.ar_count;
        @(posedge clk);
        issue_fetch(32'h0000_0304);
        issue_load(32'h0000_0348);
        release_strobes();
        fork
            wait_fetch(cycles, f_data);
            wait_load(l_data);
        join
        check("instr", init_word(32'h0000_0304), f_data);
        check("load data", init_word(32'h0000_0348), l_data);
        check("ar count", n + 2, axi_mem_model_inst.ar_count);
        check("first arid", DATA_ID, axi_mem_model_inst.ar_id_log[n]);
        check("second arid", INST_ID, axi_mem_model_inst.ar_id_log[n + 1]);
        check("first araddr", 32'h0000_0348, axi_mem_model_inst.ar_addr_log[n]);
        check("second araddr", 32'h0000_0300, axi_mem_model_inst.ar_addr_log[n + 1]);
        end_test();
    endtask

    task automatic test_store_during_fetch();
        int          cycles;
        logic [31:0] f_data;
        begin_test("store_during_fetch");
        @(posedge clk);
        issue_fetch(32'h0000_040c);
        release_strobes();
        issue_store(32'h0000_0510, $urandom, 4'b0110);  // While the refill is pending
        release_strobes();
        fork
            wait_fetch(cycles, f_data);
            wait_store();
        join
        check("instr", init_word(32'h0000_040c), f_data);
        end_test();
    endtask

    initial begin : watchdog
        #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
        $display("ERROR: run timed out before all tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        arst_n_i       = 1'b0;
        fetch_strobe_i = 1'b0;
        fetch_addr_i   = '0;
        load_strobe_i  = 1'b0;
        load_addr_i    = '0;
        store_strobe_i = 1'b0;
        store_addr_i   = '0;
        store_data_i   = '0;
        store_strb_i   = '0;
        err_count      = 0;
        check_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;

        test_fetch_miss();
        test_fetch_hit();
        test_line_replace();
        test_store_then_load();
        test_fetch_and_load();
        test_store_during_fetch();

        @(posedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== mem_subsys_top.f ====
hw/mem_bus_pkg.sv
hw/mem_req_if.sv
hw/fetch_line_buffer.sv
hw/data_access_unit.sv
hw/bus_arbiter.sv
hw/mem_subsys_top.sv
tests/axi_mem_model.sv
tests/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - hw/mem_bus_pkg.sv
  - hw/mem_req_if.sv
  - hw/fetch_line_buffer.sv
  - hw/data_access_unit.sv
  - hw/bus_arbiter.sv
  - hw/mem_subsys_top.sv
  - target: test
    files:
      - tests/axi_mem_model.sv
      - tests/tb_mem_subsys.sv
